/* rom_subsys.f */
verilog/rom_pkg.sv
verilog/rom_slot_if.sv
verilog/rom_cache_slot.sv
verilog/rom_fetch_arb.sv
verilog/rom_csr.sv
verilog/rom_subsys.sv
sim/rom_subsys_sva.sv
sim/rom_checker.sv
sim/rom_subsys_tb.sv

/* Bender.yml */
package:
  name: rom_subsys

sources:
  - files:
      - verilog/rom_pkg.sv
      - verilog/rom_slot_if.sv
      - verilog/rom_cache_slot.sv
      - verilog/rom_fetch_arb.sv
      - verilog/rom_csr.sv
      - verilog/rom_subsys.sv
  - target: simulation
    files:
      - sim/rom_subsys_sva.sv
      - sim/rom_checker.sv
      - sim/rom_subsys_tb.sv

/* sim/rom_subsys_tb.sv */
// Testbench top for the ROM fetch subsystem; runs the stimulus table against a modeled memory.
module rom_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rom_pkg::*;

    localparam int act_read  = 0;                       // Client read; slot 2 drives both.
    localparam int act_wr    = 1;                       // Register write.
    localparam int act_rd    = 2;                       // Register read and compare.
    localparam int act_first = 3;                       // First fetch word since the read.
    localparam int act_last  = 4;                       // Latest fetch word.
    localparam int act_slow  = 5;                       // Switch memory to slow mode.
    localparam int slow_cycles = 30;

    logic clk = 1'b0;
    logic rst_n;
    logic [rom_aw-1:0] slot0_addr, slot1_addr;
    logic slot0_addr_ok, slot1_addr_ok, slot0_data_ok, slot1_data_ok;
    logic [7:0] slot0_dout;
    logic [15:0] slot1_dout;
    logic mem_req, mem_ack;
    logic [mem_aw-1:0] mem_addr;
    mem_word_t mem_rdata;
    logic [csr_aw-1:0] s_axi_awaddr, s_axi_araddr;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
    logic s_axi_arvalid, s_axi_arready, s_axi_rvalid, s_axi_rready;
    logic [31:0] s_axi_wdata, s_axi_rdata;
    logic [3:0] s_axi_wstrb;
    logic [1:0] s_axi_bresp, s_axi_rresp;

    // Stimulus table columns.
    string t_name[$];
    int t_slot[$];
    logic [rom_aw-1:0] t_addr[$];
    int t_act[$];
    logic [csr_aw-1:0] t_reg[$];
    logic [31:0] t_val[$];

    logic [31:0] lcg_state = 32'd39790;
    logic slow = 1'b0;
    int mem_wait = -1;                                  // Cycles left before mem_ack.

    always #4 clk = ~clk;

    rom_subsys rom_subsys_inst (.*);

    rom_checker chk (.*);

    bind rom_fetch_arb rom_subsys_sva sva_inst (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_ack(mem_ack),
        .req0(slot0.req), .req1(slot1.req), .fill0(slot0.fill), .fill1(slot1.fill)
    );

    function automatic logic [31:0] word_hash(input logic [mem_aw-1:0] a);
        logic [31:0] x;
        x = {{(32-mem_aw){1'b0}}, a} ^ 32'h5a3c_96e1;
        return {x[24:0], x[31:25]};
    endfunction

    function int next_delay(input int lo, input int span);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lo + int'(lcg_state[30:16]) % span;
    endfunction

    task automatic add_row(input string name, input int slot, input logic [rom_aw-1:0] addr,
                           input int act, input logic [csr_aw-1:0] ra, input logic [31:0] val);
        t_name.push_back(name);
        t_slot.push_back(slot);
        t_addr.push_back(addr);
        t_act.push_back(act);
        t_reg.push_back(ra);
        t_val.push_back(val);
    endtask

    // Memory model answers after a random delay.
    always @(negedge clk) begin
        mem_ack <= 1'b0;
        if (mem_req && !mem_ack) begin
            if (mem_wait < 0) begin
                mem_wait = slow ? next_delay(20, 11) : next_delay(1, 8);
            end
            if (mem_wait <= 1) begin
                mem_ack   <= 1'b1;
                mem_rdata <= word_hash(mem_addr);
                mem_wait  = -1;
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    task automatic axi_write(input logic [csr_aw-1:0] a, input logic [31:0] d);
        @(negedge clk);
        s_axi_awaddr  <= a;
        s_axi_wdata   <= d;
        s_axi_awvalid <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        do @(posedge clk); while (!(s_axi_awready && s_axi_wready));  // Taken at this edge.
        @(negedge clk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        while (!s_axi_bvalid) @(negedge clk);
        chk.check_value(32'h0, 32'(s_axi_bresp));       // Expect OKAY.
    endtask

    task automatic axi_read(input logic [csr_aw-1:0] a, output logic [31:0] d);
        @(negedge clk);
        s_axi_araddr  <= a;
        s_axi_arvalid <= 1'b1;
        do @(posedge clk); while (!s_axi_arready);
        @(negedge clk);
        s_axi_arvalid <= 1'b0;
        while (!s_axi_rvalid) @(negedge clk);
        d = s_axi_rdata;
        chk.check_value(32'h0, 32'(s_axi_rresp));       // Expect OKAY.
    endtask

    task automatic client_read(input int slot, input logic [rom_aw-1:0] addr, output int cycles);
        @(negedge clk);
        slot0_addr    <= addr;
        slot1_addr    <= (slot == 2) ? addr + 20'h100 : addr;
        slot0_addr_ok <= (slot != 1);
        slot1_addr_ok <= (slot != 0);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!((slot == 1 || slot0_data_ok) && (slot == 0 || slot1_data_ok)));
        slot0_addr_ok <= 1'b0;
        slot1_addr_ok <= 1'b0;
    endtask

    initial begin
        int acks;
        int cycles;
        logic [31:0] rdata;
        {slot0_addr, slot1_addr, slot0_addr_ok, slot1_addr_ok} = '0;
        {s_axi_awaddr, s_axi_araddr, s_axi_awvalid, s_axi_wvalid, s_axi_arvalid} = '0;
        s_axi_wdata = '0;
        s_axi_wstrb = 4'hf;
        s_axi_bready = 1'b1;
        s_axi_rready = 1'b1;
        mem_ack = 1'b0;
        mem_rdata = '0;
        rst_n = 1'b0;
        add_row("byte_0", 0, 20'h00000, act_read, 0, 0);
        add_row("byte_1", 0, 20'h00001, act_read, 0, 0);
        add_row("byte_2", 0, 20'h00002, act_read, 0, 0);
        add_row("byte_3", 0, 20'h00003, act_read, 0, 0);
        add_row("half_lo", 1, 20'h00000, act_read, 0, 0);
        add_row("half_hi", 1, 20'h00002, act_read, 0, 0);
        add_row("half_miss_lo", 1, 20'h10000, act_read, 0, 0);
        add_row("half_miss_hi", 1, 20'h10002, act_read, 0, 0);
        add_row("cnt0_clear", 0, 0, act_wr, csr_cnt0, 32'h0);
        add_row("repl_a0", 0, 20'h00000, act_read, 0, 0);
        add_row("repl_b0", 0, 20'h00100, act_read, 0, 0);
        add_row("repl_a1", 0, 20'h00002, act_read, 0, 0);
        add_row("repl_c", 0, 20'h00200, act_read, 0, 0);
        add_row("repl_a2", 0, 20'h00001, act_read, 0, 0);
        add_row("repl_b1", 0, 20'h00102, act_read, 0, 0);
        add_row("repl_count", 0, 0, act_rd, csr_cnt0, 32'd4);
        add_row("repl_last", 0, 0, act_last, 0, 32'h40);
        add_row("prio0_read", 2, 20'h00300, act_read, 0, 0);
        add_row("prio0_first", 0, 0, act_first, 0, 32'hc0);
        add_row("ctrl_write", 0, 0, act_wr, csr_ctrl, 32'h1);
        add_row("ctrl_readback", 0, 0, act_rd, csr_ctrl, 32'h1);
        add_row("prio1_read", 2, 20'h00500, act_read, 0, 0);
        add_row("prio1_first", 0, 0, act_first, 0, 32'h180);
        add_row("id_read", 0, 0, act_rd, csr_id, 32'h524f_4d31);
        add_row("id_write", 0, 0, act_wr, csr_id, 32'h0);
        add_row("id_reread", 0, 0, act_rd, csr_id, 32'h524f_4d31);
        add_row("cnt1_clear", 0, 0, act_wr, csr_cnt1, 32'h0);
        add_row("cnt1_read", 0, 0, act_rd, csr_cnt1, 32'h0);
        add_row("slow_mem", 0, 0, act_slow, 0, 0);
        add_row("stall_byte", 0, 20'h07003, act_read, 0, 0);
        add_row("stall_half", 1, 20'h09002, act_read, 0, 0);
        add_row("stall_both", 2, 20'h0a001, act_read, 0, 0);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        acks = 0;
        while (acks < 2) begin                          // Empty caches fetch word 0 first.
            @(negedge clk);
            if (mem_ack) acks++;
        end
        repeat (3) @(negedge clk);
        for (int i = 0; i < t_name.size(); i++) begin
            chk.begin_test(t_name[i]);
            case (t_act[i])
                act_read: begin
                    chk.mark_fetches();
                    client_read(t_slot[i], t_addr[i], cycles);
                    if (slow) chk.check_at_least(20, cycles);
                end
                act_wr: axi_write(t_reg[i], t_val[i]);
                act_rd: begin
                    axi_read(t_reg[i], rdata);
                    chk.check_value(t_val[i], rdata);
                end
                act_first: chk.check_value(t_val[i], 32'(chk.first_addr));
                act_last: chk.check_value(t_val[i], 32'(chk.last_addr));
                default: slow = 1'b1;
            endcase
            chk.end_test();
        end
        chk.report();
        if (chk.fail_count == 0 && rom_subsys_inst.u_arb.sva_inst.err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog scaled to the table length.
    initial begin
        @(posedge rst_n);
        #(t_name.size() * 40 * slow_cycles * 8);
        $display("Timeout: the run did not finish in the allotted time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* sim/rom_checker.sv */
// Testbench checker; watches client and memory ports, compares results and keeps the counts.
module rom_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic [rom_pkg::rom_aw-1:0] slot0_addr,
    input logic                       slot0_data_ok,
    input logic [7:0]                 slot0_dout,
    input logic [rom_pkg::rom_aw-1:0] slot1_addr,
    input logic                       slot1_data_ok,
    input logic [15:0]                slot1_dout,
    input logic                       mem_req,
    input logic [rom_pkg::mem_aw-1:0] mem_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import rom_pkg::*;

    string             cur_name = "warmup";
    int                test_errs = 0;
    int                pass_count = 0;
    int                fail_count = 0;
    logic              d0_q = 1'b0;
    logic              d1_q = 1'b0;
    logic              req_q = 1'b0;
    logic              have_first = 1'b0;
    logic [mem_aw-1:0] first_addr = '0;                 // First fetch since mark.
    logic [mem_aw-1:0] last_addr = '0;                  // Most recent fetch.

    // Same fixed hash as the memory model.
    function automatic logic [31:0] word_hash(input logic [mem_aw-1:0] a);
        logic [31:0] x;
        x = {{(32-mem_aw){1'b0}}, a} ^ 32'h5a3c_96e1;
        return {x[24:0], x[31:25]};                     // Rotate left by 7.
    endfunction

    task automatic begin_test(input string name);
        cur_name  = name;
        test_errs = 0;
    endtask

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s: expected %h, actual %h", cur_name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_at_least(input int min_cycles, input int got);
        if (got < min_cycles) begin
            $display("[ERROR] %s: expected data_ok after at least %0d cycles, actual %0d",
                     cur_name, min_cycles, got);
            test_errs++;
        end
    endtask

    task automatic mark_fetches();
        have_first = 1'b0;                              // Restart the order log.
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("[PASS] %s", cur_name);
            pass_count++;
        end else begin
            $display("[FAIL] %s", cur_name);
            fail_count++;
        end
    endtask

    task automatic report();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    endtask

    // Sampled mid-cycle, where every DUT output is settled.
    always @(negedge clk) begin
        if (rst_n) begin
            if (slot0_data_ok && !d0_q) begin           // Byte lane by bits 1 and 0.
                check_value(32'(word_hash(slot0_addr[rom_aw-1:2]) >> (8 * slot0_addr[1:0])
                                & 32'hff), 32'(slot0_dout));
            end
            if (slot1_data_ok && !d1_q) begin           // Halfword by bit 1.
                check_value(32'(word_hash(slot1_addr[rom_aw-1:2]) >> (16 * slot1_addr[1])
                                & 32'hffff), 32'(slot1_dout));
            end
            if (mem_req && !req_q) begin
                last_addr = mem_addr;
                if (!have_first) begin
                    first_addr = mem_addr;
                    have_first = 1'b1;
                end
            end
            d0_q  = slot0_data_ok;
            d1_q  = slot1_data_ok;
            req_q = mem_req;
        end
    end

endmodule

/* sim/rom_subsys_sva.sv */
// Handshake assertions for the fetch arbiter; bound into rom_fetch_arb by the testbench.
module rom_subsys_sva (
    input logic clk,
    input logic rst_n,
    input logic mem_req,
    input logic mem_ack,
    input logic req0,
    input logic req1,
    input logic fill0,
    input logic fill1
);
    timeunit 1ns;
    timeprecision 1ps;

    int err_count = 0;                                  // Assertion failures so far.

    // Request stays up until the memory answers.
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else begin
            $error("mem_req dropped before mem_ack");
            err_count++;
        end

    a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack |=> !mem_req)
        else begin
            $error("mem_req still high after mem_ack");
            err_count++;
        end

    a_fill0_req: assert property (@(posedge clk) disable iff (!rst_n) fill0 |-> req0)
        else begin
            $error("slot 0 filled without a pending request");
            err_count++;
        end

    a_fill1_req: assert property (@(posedge clk) disable iff (!rst_n) fill1 |-> req1)
        else begin
            $error("slot 1 filled without a pending request");
            err_count++;
        end

    // One refill per memory answer.
    a_one_fill: assert property (@(posedge clk) disable iff (!rst_n)
        fill0 || fill1 |-> $past(mem_ack))
        else begin
            $error("fill without a memory answer in the previous cycle");
            err_count++;
        end

endmodule

/* verilog/rom_subsys.sv */
// Top level of the ROM fetch subsystem; two cached clients share one external memory port.
module rom_subsys (
    input  logic                       clk,
    input  logic                       rst_n,
    // Byte client.
    input  logic [rom_pkg::rom_aw-1:0] slot0_addr,
    input  logic                       slot0_addr_ok,
    output logic                       slot0_data_ok,
    output logic [7:0]                 slot0_dout,
    // Halfword client.
    input  logic [rom_pkg::rom_aw-1:0] slot1_addr,
    input  logic                       slot1_addr_ok,
    output logic                       slot1_data_ok,
    output logic [15:0]                slot1_dout,
    // External memory.
    output logic                       mem_req,
    output logic [rom_pkg::mem_aw-1:0] mem_addr,
    input  logic                       mem_ack,
    input  rom_pkg::mem_word_t         mem_rdata,
    // Register port.
    input  logic [rom_pkg::csr_aw-1:0] s_axi_awaddr,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [31:0]                s_axi_wdata,
    input  logic [3:0]                 s_axi_wstrb,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic [1:0]                 s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    input  logic [rom_pkg::csr_aw-1:0] s_axi_araddr,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [31:0]                s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready
);

    logic [1:0] fetch_done;                             // Arbiter to counters.
    logic       prio_swap;                              // Control bit to arbiter.

    rom_slot_if slot0_if ();
    rom_slot_if slot1_if ();

    rom_cache_slot #(.dw(8)) u_slot0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (slot0_addr),
        .addr_ok (slot0_addr_ok),
        .data_ok (slot0_data_ok),
        .dout    (slot0_dout),
        .mem     (slot0_if.cache)
    );

    rom_cache_slot #(.dw(16)) u_slot1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (slot1_addr),
        .addr_ok (slot1_addr_ok),
        .data_ok (slot1_data_ok),
        .dout    (slot1_dout),
        .mem     (slot1_if.cache)
    );

    rom_fetch_arb u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot0      (slot0_if.arbiter),
        .slot1      (slot1_if.arbiter),
        .prio_swap  (prio_swap),
        .fetch_done (fetch_done),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    rom_csr u_csr (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .fetch_done    (fetch_done),
        .prio_swap     (prio_swap)
    );

endmodule

/* verilog/rom_csr.sv */
// AXI4-Lite register block for the fetch subsystem; holds priority control, fetch counters and ID.
module rom_csr (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [rom_pkg::csr_aw-1:0] s_axi_awaddr,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [31:0]                s_axi_wdata,
    input  logic [3:0]                 s_axi_wstrb,
    input  logic                       s_axi_wvalid,
    output logic                       s_axi_wready,
    output logic [1:0]                 s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    input  logic [rom_pkg::csr_aw-1:0] s_axi_araddr,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic [31:0]                s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,
    input  logic [1:0]                 fetch_done,      // One pulse per finished fetch.
    output logic                       prio_swap
);
    import rom_pkg::*;

    logic        wr_en;                                 // Address and data taken together.
    logic        rd_en;                                 // Read address taken.
    logic [1:0]  cnt_clr;                               // Counter write strobes.
    logic [31:0] ctrl_q;
    logic [31:0] cnt_q [2];                             // Fetch counters per slot.
    logic [31:0] rd_mux;

    // One transaction of each kind at a time.
    assign wr_en         = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
    assign s_axi_awready = wr_en;
    assign s_axi_wready  = wr_en;
    assign rd_en         = s_axi_arvalid && !s_axi_rvalid;
    assign s_axi_arready = !s_axi_rvalid;

    assign s_axi_bresp = 2'b00;                         // Always OKAY.
    assign s_axi_rresp = 2'b00;

    assign cnt_clr[0] = wr_en && (s_axi_awaddr == csr_cnt0);
    assign cnt_clr[1] = wr_en && (s_axi_awaddr == csr_cnt1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
            ctrl_q       <= '0;
            cnt_q[0]     <= '0;
            cnt_q[1]     <= '0;
        end else begin
            // Write response.
            if (wr_en) begin
                s_axi_bvalid <= 1'b1;
            end else if (s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
            end
            // Read response.
            if (rd_en) begin
                s_axi_rvalid <= 1'b1;
            end else if (s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
            end
            if (wr_en && s_axi_awaddr == csr_ctrl) begin
                for (int b = 0; b < 4; b++) begin
                    if (s_axi_wstrb[b]) begin
                        ctrl_q[8*b +: 8] <= s_axi_wdata[8*b +: 8];
                    end
                end
            end
            // Write of any value clears; it wins over a fetch.
            for (int i = 0; i < 2; i++) begin
                if (cnt_clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (fetch_done[i]) begin
                    cnt_q[i] <= cnt_q[i] + 32'd1;
                end
            end
        end
    end

    always_comb begin
        unique case (s_axi_araddr)
            csr_ctrl: rd_mux = ctrl_q;
            csr_cnt0: rd_mux = cnt_q[0];
            csr_cnt1: rd_mux = cnt_q[1];
            csr_id:   rd_mux = rom_id_value;
            default:  rd_mux = '0;                      // Unaligned reads.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_axi_rdata <= rd_mux;                      // Held while rvalid waits.
        end
    end

    assign prio_swap = ctrl_q[0];

endmodule

/* verilog/rom_fetch_arb.sv */
// Fixed-priority fetch arbiter; serves slot misses one at a time on the external memory port.
module rom_fetch_arb (
    input  logic                       clk,
    input  logic                       rst_n,
    rom_slot_if.arbiter                slot0,
    rom_slot_if.arbiter                slot1,
    input  logic                       prio_swap,       // Slot 1 wins ties when set.
    output logic [1:0]                 fetch_done,      // Finished fetch per slot.
    output logic                       mem_req,
    output logic [rom_pkg::mem_aw-1:0] mem_addr,
    input  logic                       mem_ack,
    input  rom_pkg::mem_word_t         mem_rdata
);
    import rom_pkg::*;

    typedef enum logic [1:0] {
        st_idle,                                        // No fetch in flight.
        st_wait,                                        // Memory request out.
        st_fill                                         // Word back to the slot.
    } state_t;

    state_t    state;
    logic      grant;                                   // Slot being served.
    logic      pick;                                    // Winner among pending slots.
    logic      any_req;
    logic      fill_s;
    mem_word_t rdata_q;                                 // Word from the memory.

    assign any_req = slot0.req || slot1.req;

    // Slot 0 first unless swapped.
    assign pick = prio_swap ? slot1.req : !slot0.req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            grant <= 1'b0;
        end else begin
            unique case (state)
                st_idle: begin
                    if (any_req) begin
                        grant <= pick;                  // Held for the whole fetch.
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem_ack) begin
                        state <= st_fill;               // No timeout on slow memory.
                    end
                end
                st_fill: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    // Memory port follows the granted slot.
    assign mem_req  = (state == st_wait);
    assign mem_addr = grant ? slot1.word_addr : slot0.word_addr;

    // Refill goes to the granted slot only.
    assign fill_s          = (state == st_fill);
    assign slot0.fill      = fill_s && !grant;
    assign slot1.fill      = fill_s && grant;
    assign slot0.fill_data = rdata_q;
    assign slot1.fill_data = rdata_q;

    assign fetch_done = {fill_s && grant, fill_s && !grant};

endmodule

/* verilog/rom_cache_slot.sv */
// Two-entry word cache for one ROM client; instantiated per slot with dw of 8 or 16.
module rom_cache_slot #(
    parameter int dw = 8                                // Client data width, 8 or 16.
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [rom_pkg::rom_aw-1:0] addr,            // Client byte address.
    input  logic                       addr_ok,         // Address valid.
    output logic                       data_ok,         // Data ready strobe.
    output logic [dw-1:0]              dout,
    rom_slot_if.cache                  mem
);
    import rom_pkg::*;

    localparam int lsb    = $clog2(dw / 8);             // Lowest lane select bit.
    localparam int lane_w = 2 - lsb;                    // Lanes per word, as bits.

    // Cached words and their tags.
    logic [mem_aw-1:0] tag0;
    logic [mem_aw-1:0] tag1;
    mem_word_t         word0;
    mem_word_t         word1;

    logic              empty;                           // No valid entry yet.
    logic              victim;                          // Entry the next fill replaces.
    logic [mem_aw-1:0] wa;                              // Word address of the client.
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic              hit_now;                         // Valid request that hits.
    logic              same_addr;                       // Address unchanged since last edge.
    logic [1:0]        ok_sr;                           // Hit delay line.
    logic [rom_aw-1:0] addr_q;
    logic [lane_w-1:0] lane;
    mem_word_t         word_sel;

    assign wa        = addr[rom_aw-1:2];
    assign hit0      = !empty && (tag0 == wa);
    assign hit1      = !empty && (tag1 == wa);
    assign hit       = hit0 || hit1;
    assign hit_now   = addr_ok && hit;
    assign same_addr = (addr == addr_q);

    // An empty cache always asks for the current word.
    assign mem.req       = empty || (addr_ok && !hit);
    assign mem.word_addr = wa;

    assign word_sel = hit0 ? word0 : word1;             // Entry 1 when neither hits.
    assign lane     = addr[1:lsb];                      // Byte or halfword select.

    // Control state.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty   <= 1'b1;
            victim  <= 1'b0;
            ok_sr   <= '0;
            data_ok <= 1'b0;
        end else begin
            if (mem.fill) begin
                empty <= 1'b0;
                if (!empty) begin
                    victim <= ~victim;                  // Alternate entries.
                end
            end
            // Restart the delay when the hit breaks or the address moves.
            ok_sr[0] <= hit_now;
            ok_sr[1] <= ok_sr[0] && hit_now && same_addr;
            data_ok  <= ok_sr[1] && hit_now && same_addr;
        end
    end

    // Entries and output lane.
    always_ff @(posedge clk) begin
        addr_q <= addr;
        if (mem.fill) begin
            if (empty || !victim) begin
                tag0  <= wa;                            // First fill loads both.
                word0 <= mem.fill_data;
            end
            if (empty || victim) begin
                tag1  <= wa;
                word1 <= mem.fill_data;
            end
        end
        if (hit_now) begin
            dout <= word_sel[lane*dw +: dw];            // Lane picked by low bits.
        end
    end

endmodule

/* verilog/rom_slot_if.sv */
// Miss request and refill path between one cache slot and the fetch arbiter; one instance per slot.
interface rom_slot_if;
    import rom_pkg::*;

    logic              req;                             // Miss pending.
    logic [mem_aw-1:0] word_addr;                       // Word wanted by the cache.
    logic              fill;                            // One-cycle refill strobe.
    mem_word_t         fill_data;                       // Valid with fill.

    // Cache side raises misses and takes refills.
    modport cache (
        output req,
        output word_addr,
        input  fill,
        input  fill_data
    );

    // Arbiter side serves misses.
    modport arbiter (
        input  req,
        input  word_addr,
        output fill,
        output fill_data
    );

endinterface

/* verilog/rom_pkg.sv */
// Shared widths, memory word type and register offsets; imported by every block of the subsystem.
package rom_pkg;

    // Client side.
    localparam int rom_aw = 20;                         // Byte address width of the clients.

    // Memory side.
    localparam int mem_aw = rom_aw - 2;                 // One address per 32-bit word.

    typedef logic [31:0] mem_word_t;                    // One external memory word.

    // Register block.
    localparam int csr_aw = 4;                          // AXI4-Lite address width.

    localparam logic [csr_aw-1:0] csr_ctrl = csr_aw'('h0);  // Priority control.
    localparam logic [csr_aw-1:0] csr_cnt0 = csr_aw'('h4);  // Slot 0 fetch count.
    localparam logic [csr_aw-1:0] csr_cnt1 = csr_aw'('h8);  // Slot 1 fetch count.
    localparam logic [csr_aw-1:0] csr_id   = csr_aw'('hc);  // Read-only ID word.

    // ASCII "ROM1".
    localparam mem_word_t rom_id_value = 32'h524f_4d31;

endpackage
